/* barrier_pkg.sv */
package barrier_pkg;

    localparam int SLOT_COUNT = 4;  // connection slots per request
    localparam int CONN_ID_W  = 4;
    localparam int CTX_ID_W   = 4;
    localparam int OPCODE_W   = 4;

    localparam logic [OPCODE_W-1:0] OP_BARRIER = 4'd5;
    localparam logic [OPCODE_W-1:0] OP_ANSWER  = 4'd6;

    typedef struct packed {
        logic                 enable;
        logic [CONN_ID_W-1:0] conn_id;
    } slot_t;

    // request as loaded by software
    typedef struct packed {
        logic                  table_sel;  // 0 picks table 0, 1 picks table 1
        logic [CTX_ID_W-1:0]   ctx_id;
        slot_t [SLOT_COUNT-1:0] slots;     // slot 3 in the top bits
    } req_view_t;

    // context table as held by software
    typedef struct packed {
        logic                  active;
        logic [CTX_ID_W-1:0]   ctx_id;
        slot_t [SLOT_COUNT-1:0] slots;
    } table_view_t;

    typedef union packed {
        req_view_t   req;
        table_view_t tbl;
    } barrier_word_u;

    typedef struct packed {
        logic [CONN_ID_W-1:0] conn_id;
        logic [CTX_ID_W-1:0]  ctx_id;
        logic                 broadcast;  // low for an answer
    } rx_msg_t;

    typedef struct packed {
        logic [CONN_ID_W-1:0] conn_id;
        logic [CTX_ID_W-1:0]  ctx_id;
        logic [OPCODE_W-1:0]  opcode;
    } chan_msg_t;

endpackage

/* barrier_req_buffer.sv */
`timescale 1ns/1ps

module barrier_req_buffer
    import barrier_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  barrier_word_u in_word,
    input  logic          pop,
    output logic          head_valid,
    output barrier_word_u head_word
);

    logic          tail_valid;
    barrier_word_u tail_word;
    logic          head_load;

    // head takes the tail whenever it is empty or retired
    assign head_load = !head_valid || pop;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head_valid <= 1'b0;
            tail_valid <= 1'b0;
        end
        else
        begin
            if (head_load)
            begin
                head_valid <= tail_valid;
            end
            if (head_load || !tail_valid)
            begin
                tail_valid <= in_valid;  // lost if both entries are full
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (head_load)
        begin
            head_word <= tail_word;
        end
        if (head_load || !tail_valid)
        begin
            tail_word <= in_word;
        end
    end

endmodule

/* barrier_scheduler.sv */
`timescale 1ns/1ps

module barrier_scheduler
    import barrier_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          head_valid,
    input  barrier_word_u head_word,
    output logic          head_pop,
    input  logic          rx_valid,
    input  rx_msg_t       rx_msg,
    output logic          rx_ready,
    output chan_msg_t     chan,
    output logic          chan_valid,
    input  logic          chan_ready
);

    // state value is the index of the first slot still to be searched
    localparam logic [1:0] ST_IDLE = 2'd0;

    logic [1:0] state;
    logic [1:0] next_state;
    chan_msg_t  next_chan;
    logic       next_chan_valid;
    logic       chan_free;
    logic       slot_found;
    logic [1:0] slot_idx;
    logic       slot_more;
    chan_msg_t  barrier_msg;
    chan_msg_t  answer_msg;

    assign chan_free = !chan_valid || chan_ready;

    // next enabled slot at or after the search start
    always_comb
    begin
        slot_found = 1'b0;
        slot_idx   = 2'd0;
        slot_more  = 1'b0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--)
        begin
            if (i >= state && head_word.req.slots[i].enable)
            begin
                slot_found = 1'b1;
                slot_idx   = 2'(i);
            end
        end
        for (int i = 0; i < SLOT_COUNT; i++)
        begin
            if (slot_found && i > slot_idx && head_word.req.slots[i].enable)
            begin
                slot_more = 1'b1;  // another slot follows this one
            end
        end
    end

    assign barrier_msg = '{conn_id: head_word.req.slots[slot_idx].conn_id,
                           ctx_id:  head_word.req.ctx_id,
                           opcode:  OP_BARRIER};
    assign answer_msg  = '{conn_id: rx_msg.conn_id,
                           ctx_id:  rx_msg.ctx_id,
                           opcode:  OP_ANSWER};

    always_comb
    begin
        next_state      = state;
        next_chan       = chan;
        next_chan_valid = chan_valid;
        head_pop        = 1'b0;
        rx_ready        = 1'b0;
        if (!chan_free)
        begin
            // stall with the channel held
        end
        else if (state != ST_IDLE || head_valid)
        begin
            next_chan       = barrier_msg;
            next_chan_valid = slot_found;
            head_pop        = !slot_more;  // last slot or none enabled
            next_state      = slot_more ? 2'(slot_idx + 2'd1) : ST_IDLE;
        end
        else
        begin
            rx_ready        = rx_valid;
            next_chan       = answer_msg;
            next_chan_valid = rx_valid && rx_msg.broadcast;  // answers need no echo
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            chan_valid <= 1'b0;
        end
        else
        begin
            state      <= next_state;
            chan_valid <= next_chan_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        chan <= next_chan;
    end

endmodule

/* barrier_context_tracker.sv */
`timescale 1ns/1ps

module barrier_context_tracker
    import barrier_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  barrier_word_u table_word,
    input  logic          req_done,
    input  logic          rx_accept,
    input  rx_msg_t       rx_msg,
    input  logic          clean,
    output logic          answer
);

    logic                  req_seen;
    logic [SLOT_COUNT-1:0] bcast_map;   // broadcasts received per slot
    logic [SLOT_COUNT-1:0] answer_map;  // answers received per slot
    logic [SLOT_COUNT-1:0] seen_map;
    logic [SLOT_COUNT-1:0] mark;
    logic [SLOT_COUNT-1:0] en_mask;
    logic                  ctx_match;

    assign ctx_match = rx_accept && table_word.tbl.active
                       && rx_msg.ctx_id == table_word.tbl.ctx_id;
    assign seen_map  = rx_msg.broadcast ? bcast_map : answer_map;

    // highest matching slot not yet marked
    always_comb
    begin
        mark    = '0;
        en_mask = '0;
        for (int i = 0; i < SLOT_COUNT; i++)
        begin
            en_mask[i] = table_word.tbl.slots[i].enable;
            if (table_word.tbl.slots[i].enable && !seen_map[i]
                && table_word.tbl.slots[i].conn_id == rx_msg.conn_id)
            begin
                mark    = '0;
                mark[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || clean)
        begin
            req_seen   <= 1'b0;
            bcast_map  <= '0;
            answer_map <= '0;
            answer     <= 1'b0;
        end
        else
        begin
            if (req_done)
            begin
                req_seen <= 1'b1;
            end
            if (ctx_match && rx_msg.broadcast)
            begin
                bcast_map <= bcast_map | mark;
            end
            if (ctx_match && !rx_msg.broadcast)
            begin
                answer_map <= answer_map | mark;
            end
            answer <= req_seen && ((bcast_map & answer_map & en_mask) == en_mask);
        end
    end

endmodule

/* barrier_tx.sv */
`timescale 1ns/1ps

module barrier_tx
    import barrier_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid,
    input  barrier_word_u req_word,
    input  barrier_word_u table_0,
    input  barrier_word_u table_1,
    input  logic          clean_0,
    input  logic          clean_1,
    input  rx_msg_t       rx_msg,
    input  logic          rx_valid,
    output logic          rx_ready,
    output chan_msg_t     chan,
    output logic          chan_valid,
    input  logic          chan_ready,
    output logic          answer_0,
    output logic          answer_1
);

    logic          head_valid;
    barrier_word_u head_word;
    logic          head_pop;
    logic          req_done_0;
    logic          req_done_1;
    logic          rx_accept;

    assign req_done_0 = head_pop && head_valid && !head_word.req.table_sel;
    assign req_done_1 = head_pop && head_valid && head_word.req.table_sel;
    assign rx_accept  = rx_valid && rx_ready;

    barrier_req_buffer req_buf (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (req_valid),
        .in_word    (req_word),
        .pop        (head_pop),
        .head_valid (head_valid),
        .head_word  (head_word)
    );

    barrier_scheduler sched (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .head_word  (head_word),
        .head_pop   (head_pop),
        .rx_valid   (rx_valid),
        .rx_msg     (rx_msg),
        .rx_ready   (rx_ready),
        .chan       (chan),
        .chan_valid (chan_valid),
        .chan_ready (chan_ready)
    );

    barrier_context_tracker track_0 (
        .clk        (clk),
        .reset      (reset),
        .table_word (table_0),
        .req_done   (req_done_0),
        .rx_accept  (rx_accept),
        .rx_msg     (rx_msg),
        .clean      (clean_0),
        .answer     (answer_0)
    );

    barrier_context_tracker track_1 (
        .clk        (clk),
        .reset      (reset),
        .table_word (table_1),
        .req_done   (req_done_1),
        .rx_accept  (rx_accept),
        .rx_msg     (rx_msg),
        .clean      (clean_1),
        .answer     (answer_1)
    );

endmodule

/* barrier_tx_checker.sv */
`timescale 1ns/1ps

module barrier_tx_checker
    import barrier_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid,
    input  barrier_word_u req_word,
    input  logic          clean_0,
    input  logic          clean_1,
    input  rx_msg_t       rx_msg,
    input  logic          rx_valid,
    input  logic          rx_ready,
    input  chan_msg_t     chan,
    input  logic          chan_valid,
    input  logic          chan_ready,
    input  logic          answer_0,
    input  logic          answer_1,
    input  logic [1:0]    answer_exp,
    input  logic          answer_check,
    output logic          drained,
    output int            error_count
);

    typedef struct packed {
        logic [2:0]                 count;
        chan_msg_t [SLOT_COUNT-1:0] msgs;
    } msg_list_t;

    chan_msg_t  exp_q[$];
    chan_msg_t  front;
    chan_msg_t  stall_chan;
    logic       stall_seen;
    logic [1:0] clean_seen;
    logic [1:0] answers;
    logic [1:0] cleans;
    int         quiet_cnt;
    int         pending = 0;

    assign answers = {answer_1, answer_0};
    assign cleans  = {clean_1, clean_0};
    assign drained = pending == 0 && !chan_valid;

    initial error_count = 0;

    // messages a request or an inbound message must produce, in send order
    function automatic msg_list_t expected_msgs(input logic is_req, input barrier_word_u w,
                                                input rx_msg_t r);
        msg_list_t l;
        l = '0;
        if (is_req)
        begin
            for (int i = 0; i < SLOT_COUNT; i++)
            begin
                if (w.req.slots[i].enable)
                begin
                    l.msgs[l.count] = '{w.req.slots[i].conn_id, w.req.ctx_id, OP_BARRIER};
                    l.count = l.count + 3'd1;
                end
            end
        end
        else if (r.broadcast)
        begin
            l.msgs[0] = '{r.conn_id, r.ctx_id, OP_ANSWER};
            l.count   = 3'd1;
        end
        return l;
    endfunction

    task automatic queue_expected(input msg_list_t l);
        for (int i = 0; i < l.count; i++)
            exp_q.push_back(l.msgs[i]);
    endtask

    task automatic flag_error(input string msg);
        error_count++;
        $display("[ERROR] t=%0t: %s", $time, msg);
    endtask

    // sampled mid-cycle, inputs and flops both settled
    always @(negedge clk)
    begin
        if (reset)
        begin
            exp_q.delete();
            stall_seen = 1'b0;
            clean_seen = 2'b00;
            quiet_cnt  = 0;
        end
        else
        begin
            quiet_cnt++;
            if (stall_seen && (!chan_valid || chan !== stall_chan))
                flag_error("channel changed while stalled");
            stall_seen = chan_valid && !chan_ready;
            stall_chan = chan;
            if ((clean_seen & answers) != 2'b00)
                flag_error($sformatf("answers %b still high after clean", answers));
            clean_seen = cleans;
            if (req_valid)
                queue_expected(expected_msgs(1'b1, req_word, rx_msg));
            if (rx_valid && rx_ready)
                queue_expected(expected_msgs(1'b0, req_word, rx_msg));
            if (chan_valid && chan_ready)
            begin
                if (exp_q.size() == 0)
                    flag_error($sformatf("unexpected message %h", chan));
                else
                begin
                    front = exp_q.pop_front();
                    if (chan !== front)
                        flag_error($sformatf("message %h, expected %h", chan, front));
                end
            end
            if (req_valid || rx_valid || cleans != 2'b00 || chan_valid || exp_q.size() != 0)
                quiet_cnt = 0;
            if (answer_check && quiet_cnt >= 5 && answers !== answer_exp)
                flag_error($sformatf("answers %b, expected %b", answers, answer_exp));
            pending = exp_q.size();
        end
    end

endmodule

/* barrier_tx_tb.sv */
`timescale 1ns/1ps

module barrier_tx_tb
    import barrier_pkg::*;
();

    localparam int N_RAND     = 12;  // random requests, each followed by a random inbound
    localparam int N_DIRECTED = 19;
    localparam int MAX_CYCLES = 40 * (2 * N_RAND + N_DIRECTED) + 200;

    logic          clk;
    logic          reset;
    logic          req_valid;
    barrier_word_u req_word;
    barrier_word_u table_0;
    barrier_word_u table_1;
    logic          clean_0;
    logic          clean_1;
    rx_msg_t       rx_msg;
    logic          rx_valid;
    logic          rx_ready;
    chan_msg_t     chan;
    logic          chan_valid;
    logic          chan_ready;
    logic          answer_0;
    logic          answer_1;
    logic          drained;
    logic [1:0]    answer_exp;
    logic          answer_check;
    int            error_count;
    int            cycle_cnt;
    logic [31:0]   rnd;
    barrier_word_u req_0;
    barrier_word_u req_1;

    barrier_tx uut (.*);

    barrier_tx_checker chk (.*);

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic settle();
        @(posedge clk);
        while (!drained)
            @(posedge clk);
        repeat (8) @(posedge clk);
        #1;
    endtask

    task automatic send_req(input barrier_word_u w);
        req_word  = w;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        settle();
    endtask

    task automatic send_rx(input rx_msg_t m);
        rx_msg   = m;
        rx_valid = 1'b1;
        @(negedge clk);
        while (!rx_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        settle();
    endtask

    task automatic pulse_clean(input logic c0, input logic c1);
        clean_0 = c0;
        clean_1 = c1;
        @(posedge clk);
        #1;
        clean_0 = 1'b0;
        clean_1 = 1'b0;
        settle();
    endtask

    // broadcast and answer for every enabled connection of a table
    task automatic complete_table(input barrier_word_u t, input int idx);
        int last;
        last = 0;
        for (int i = 0; i < SLOT_COUNT; i++)
            if (t.tbl.slots[i].enable)
                last = i;
        for (int i = 0; i < SLOT_COUNT; i++)
        begin
            if (t.tbl.slots[i].enable)
            begin
                send_rx(rx_msg_t'{t.tbl.slots[i].conn_id, t.tbl.ctx_id, 1'b1});
                if (i == last)
                    answer_exp[idx] = 1'b1;  // only this answer still missing
                send_rx(rx_msg_t'{t.tbl.slots[i].conn_id, t.tbl.ctx_id, 1'b0});
            end
        end
    endtask

    task automatic drive_chan_ready();
        forever
        begin
            @(posedge clk);
            #1;
            chan_ready = ($urandom % 4) != 0;  // stalls about one cycle in four
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_word     = '0;
        clean_0      = 1'b0;
        clean_1      = 1'b0;
        rx_msg       = '0;
        rx_valid     = 1'b0;
        chan_ready   = 1'b1;
        answer_exp   = 2'b00;
        answer_check = 1'b0;
        cycle_cnt    = 0;
        table_0      = {1'b1, 4'd3, 5'h19, 5'h04, 5'h15, 5'h12};  // ctx 3, slot 2 off
        table_1      = {1'b1, 4'd7, 5'h00, 5'h1b, 5'h00, 5'h16};  // ctx 7, slots 0 and 2
        req_0        = table_0;
        req_0.req.table_sel = 1'b0;
        req_1        = table_1;
        req_1.req.table_sel = 1'b1;
        rnd = $urandom(32'h1a32);
        fork
            drive_chan_ready();
        join_none
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int k = 0; k < N_RAND; k++)
        begin
            rnd = $urandom;
            send_req(rnd[24:0]);
            rnd = $urandom;
            send_rx(rnd[8:0]);
        end
        pulse_clean(1'b1, 1'b1);
        answer_check = 1'b1;
        send_req(req_0);
        complete_table(table_0, 0);
        send_req(req_1);
        complete_table(table_1, 1);
        answer_exp[1] = 1'b0;
        pulse_clean(1'b0, 1'b1);
        send_req(req_1);  // records gone, answer_1 must stay low
        complete_table(table_1, 1);
        $display("errors: %0d", error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
barrier_pkg.sv
barrier_req_buffer.sv
barrier_scheduler.sv
barrier_context_tracker.sv
barrier_tx.sv
barrier_tx_checker.sv
barrier_tx_tb.sv
